// File: periphSubsystem.f
verilog/sysBusPkg.sv
verilog/busDecoder.sv
verilog/ledSbCtrl.sv
verilog/switchSbCtrl.sv
verilog/periphSubsystem.sv
test/periphSubsystem_assertions.sv
test/periphChecker.sv
test/periphSubsystemTb.sv

// File: Bender.yml
package:
  name: periph_subsystem

dependencies: {}

sources:
  - files:
      - verilog/sysBusPkg.sv
      - verilog/busDecoder.sv
      - verilog/ledSbCtrl.sv
      - verilog/switchSbCtrl.sv
      - verilog/periphSubsystem.sv
  - target: test
    files:
      - test/periphSubsystem_assertions.sv
      - test/periphChecker.sv
      - test/periphSubsystemTb.sv

// File: test/periphSubsystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module periphSubsystemTb import sysBusPkg::*; ();

    localparam int BLINK_HALF = 8;

    // rough cycle cost of each test, reset through decode.
    localparam int TEST_CYCLES = 6 + 36 + 80 + 14 + 57 + 14;
    localparam int RUN_LIMIT   = TEST_CYCLES + 200;

    localparam logic [31:0] ADDR_LED_VALUE = {SB_DEV_LED, SB_REG_VALUE};
    localparam logic [31:0] ADDR_LED_MODE  = {SB_DEV_LED, SB_REG_MODE};
    localparam logic [31:0] ADDR_LED_RESET = {SB_DEV_LED, SB_REG_RESET};
    localparam logic [31:0] ADDR_SW_VALUE  = {SB_DEV_SWITCH, SB_REG_VALUE};
    localparam logic [31:0] ADDR_SW_RESET  = {SB_DEV_SWITCH, SB_REG_RESET};
    localparam logic [31:0] ADDR_UNMAPPED  = 32'h0300_0000;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic [LED_WIDTH-1:0]  led;
    } refOut_t;

    logic                    clk;
    logic                    rst;
    sbReq_t                  busReq;
    logic [DATA_WIDTH-1:0]   busRdata;
    logic [SWITCH_WIDTH-1:0] switches;
    logic [LED_WIDTH-1:0]    led;
    logic                    swIrq;

    // shadow state of the model.
    logic [LED_WIDTH-1:0]    shValue;
    logic                    shMode;
    int                      shCnt;
    logic                    shIrq;
    logic [SWITCH_WIDTH-1:0] swD1;
    logic [SWITCH_WIDTH-1:0] swD2;
    logic [SWITCH_WIDTH-1:0] swD3;
    logic [DATA_WIDTH-1:0]   expRdata;
    logic                    rdPending = 1'b0;
    refOut_t                 modelOut;

    logic rdReq;
    logic wrReq;
    logic toLed;
    logic toSw;
    logic ledValueWr;
    logic ledModeWr;
    logic ledRstWr;
    logic swRstWr;
    logic swValueRd;

    int errCount;
    int testCount;
    int failedTests;
    int cycleCount = 0;

    periphSubsystem #(
        .BLINK_HALF (BLINK_HALF)
    ) u_dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .busReq_i   (busReq),
        .busRdata_o (busRdata),
        .switches_i (switches),
        .led_o      (led),
        .swIrq_o    (swIrq)
    );

    periphChecker u_checker (
        .clk_i         (clk),
        .led_i         (led),
        .expLed_i      (modelOut.led),
        .rdata_i       (busRdata),
        .expRdata_i    (expRdata),
        .rdCheck_i     (rdPending),
        .irq_i         (swIrq),
        .expIrq_i      (shIrq),
        .errCount_o    (errCount),
        .testCount_o   (testCount),
        .failedTests_o (failedTests)
    );

    // expected led and the data a read of addr would return.
    function automatic refOut_t refModel(input logic [31:0] addr, input logic [15:0] value,
                                         input logic mode, input int cnt,
                                         input logic [15:0] swSync);
        refOut_t r;
        r.led   = (mode && cnt >= BLINK_HALF) ? '0 : value;
        r.rdata = '0;
        if (addr[31:24] == SB_DEV_LED && addr[23:0] == SB_REG_VALUE) begin
            r.rdata = {16'h0000, value};
        end else if (addr[31:24] == SB_DEV_LED && addr[23:0] == SB_REG_MODE) begin
            r.rdata = {31'd0, mode};
        end else if (addr[31:24] == SB_DEV_SWITCH && addr[23:0] == SB_REG_VALUE) begin
            r.rdata = {16'h0000, swSync};
        end
        return r;
    endfunction

    assign modelOut   = refModel(busReq.addr, shValue, shMode, shCnt, swD2);
    assign rdReq      = busReq.req && !busReq.we;
    assign wrReq      = busReq.req && busReq.we;
    assign toLed      = busReq.addr[31:24] == SB_DEV_LED;
    assign toSw       = busReq.addr[31:24] == SB_DEV_SWITCH;
    assign ledValueWr = wrReq && toLed && busReq.addr[23:0] == SB_REG_VALUE
                        && busReq.wdata[31:16] == 16'h0000;
    assign ledModeWr  = wrReq && toLed && busReq.addr[23:0] == SB_REG_MODE
                        && busReq.wdata <= 32'd1;
    assign ledRstWr   = wrReq && toLed && busReq.addr[23:0] == SB_REG_RESET
                        && busReq.wdata == 32'd1;
    assign swRstWr    = wrReq && toSw && busReq.addr[23:0] == SB_REG_RESET
                        && busReq.wdata == 32'd1;
    assign swValueRd  = rdReq && toSw && busReq.addr[23:0] == SB_REG_VALUE;

    always @(posedge clk) begin
        if (rst) begin
            shValue   <= '0;
            shMode    <= 1'b0;
            shCnt     <= 0;
            shIrq     <= 1'b0;
            swD1      <= '0;
            swD2      <= '0;
            swD3      <= '0;
            expRdata  <= '0;
            rdPending <= 1'b1;    // read data must sit at zero in reset.
        end else begin
            swD1      <= switches;
            swD2      <= swD1;
            swD3      <= swD2;
            rdPending <= rdReq;
            if (rdReq) begin
                expRdata <= modelOut.rdata;
            end
            if (ledRstWr) begin
                shValue <= '0;
                shMode  <= 1'b0;
                shCnt   <= 0;
            end else begin
                if (ledValueWr) begin
                    shValue <= busReq.wdata[15:0];
                end
                if (ledModeWr) begin
                    shMode <= busReq.wdata[0];
                    shCnt  <= 0;
                end else if (shMode) begin
                    shCnt <= (shCnt + 1) % (2 * BLINK_HALF);
                end
            end
            if (swRstWr) begin
                shIrq <= 1'b0;
            end else if (swD2 != swD3) begin
                shIrq <= 1'b1;
            end else if (swValueRd) begin
                shIrq <= 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == RUN_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        busReq = {1'b1, 1'b1, addr, data};
        @(negedge clk);
        busReq = '0;
    endtask

    task automatic busRead(input logic [31:0] addr);
        @(negedge clk);
        busReq = {1'b1, 1'b0, addr, 32'h0000_0000};
        @(negedge clk);
        busReq = '0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic changeSwitches();
        logic [15:0] pattern;
        pattern = 16'($urandom);
        if (pattern == switches) begin
            pattern = ~pattern;
        end
        @(negedge clk);
        switches = pattern;
    endtask

    task automatic waitForIrq(input int maxCycles);
        int n;
        n = 0;
        while (!swIrq && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (!swIrq) begin
            u_checker.reportProblem("swIrq_o did not rise after a switch change");
        end
    endtask

    initial begin
        logic [31:0] data;
        busReq   = '0;
        switches = '0;
        rst      = 1'b1;
        void'($urandom(86582));
        u_checker.startTest("reset_state");
        repeat (2) @(negedge clk);
        rst = 1'b0;
        idleCycles(3);
        u_checker.finishTest();

        u_checker.startTest("led_value");
        repeat (8) begin
            busWrite(ADDR_LED_VALUE, {16'h0000, 16'($urandom)});
            busRead(ADDR_LED_VALUE);
        end
        data     = $urandom;
        data[16] = 1'b1;    // upper half nonzero.
        busWrite(ADDR_LED_VALUE, data);
        busRead(ADDR_LED_VALUE);
        u_checker.finishTest();

        u_checker.startTest("blink");
        busWrite(ADDR_LED_VALUE, {16'h0000, 16'($urandom) | 16'h0001});
        busWrite(ADDR_LED_MODE, 32'd1);
        idleCycles(5 * BLINK_HALF);
        busWrite(ADDR_LED_MODE, 32'd2);
        idleCycles(20);
        busRead(ADDR_LED_MODE);
        busWrite(ADDR_LED_MODE, 32'd0);
        idleCycles(10);
        u_checker.finishTest();

        u_checker.startTest("soft_reset");
        busWrite(ADDR_LED_VALUE, {16'h0000, 16'($urandom) | 16'h8000});
        busWrite(ADDR_LED_MODE, 32'd1);
        busWrite(ADDR_LED_RESET, 32'd1);
        busRead(ADDR_LED_VALUE);
        busRead(ADDR_LED_MODE);
        idleCycles(4);
        u_checker.finishTest();

        u_checker.startTest("switches");
        repeat (4) begin
            changeSwitches();
            waitForIrq(8);
            busRead(ADDR_SW_VALUE);
        end
        changeSwitches();
        waitForIrq(8);
        busWrite(ADDR_SW_RESET, 32'd1);
        idleCycles(2);
        u_checker.finishTest();

        u_checker.startTest("decode");
        busWrite(ADDR_LED_VALUE, 32'h0000_5a3c);
        busRead(ADDR_LED_VALUE);    // nonzero read data before the unmapped read.
        busRead(ADDR_UNMAPPED);
        busRead(32'h0000_0000);
        busWrite(ADDR_UNMAPPED, 32'h0000_a5c3);
        busWrite(ADDR_UNMAPPED | 32'h24, 32'd1);
        busRead(ADDR_LED_VALUE);
        u_checker.finishTest();

        $display("%0d tests, %0d with mismatches, %0d check errors, %0d assertion failures",
                 testCount, failedTests, errCount, u_dut.u_assertions.assertFails);
        if (errCount == 0 && u_dut.u_assertions.assertFails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/periphChecker.sv
`timescale 1ns/100ps
`default_nettype none

module periphChecker import sysBusPkg::*; (
    input  logic                  clk_i,
    input  logic [LED_WIDTH-1:0]  led_i,
    input  logic [LED_WIDTH-1:0]  expLed_i,
    input  logic [DATA_WIDTH-1:0] rdata_i,
    input  logic [DATA_WIDTH-1:0] expRdata_i,
    input  logic                  rdCheck_i,
    input  logic                  irq_i,
    input  logic                  expIrq_i,
    output int                    errCount_o,
    output int                    testCount_o,
    output int                    failedTests_o
);

    string testName = "none";
    int    testErrs = 0;
    int    errCount = 0;
    int    testCount = 0;
    int    failedTests = 0;

    assign errCount_o    = errCount;
    assign testCount_o   = testCount;
    assign failedTests_o = failedTests;

    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
    endtask

    task automatic finishTest();
        @(posedge clk_i);    // last negedge compare belongs to this test.
        testCount++;
        if (testErrs == 0) begin
            $display("test %-12s passed", testName);
        end else begin
            failedTests++;
            $display("test %-12s had %0d mismatches", testName, testErrs);
        end
    endtask

    task automatic reportProblem(input string what);
        errCount++;
        testErrs++;
        $display("ERROR in %s: %s", testName, what);
    endtask

    task automatic compareValue(input string sig, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        if (actVal !== expVal) begin
            errCount++;
            testErrs++;
            $display("FAILED %s: %s expected %h, actual %h", testName, sig, expVal, actVal);
        end
    endtask

    // outputs settle after the rising edge.
    always @(negedge clk_i) begin
        compareValue("led_o", 32'(expLed_i), 32'(led_i));
        compareValue("swIrq_o", 32'(expIrq_i), 32'(irq_i));
        if (rdCheck_i) begin
            compareValue("busRdata_o", expRdata_i, rdata_i);    // only right after a read.
        end
    end

endmodule

`default_nettype wire

// File: test/periphSubsystem_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module periphSubsystemAssertions import sysBusPkg::*; (
    input logic                  clk_i,
    input logic                  rst_i,
    input sbReq_t                busReq_i,
    input logic [DATA_WIDTH-1:0] busRdata_i,
    input logic [LED_WIDTH-1:0]  led_i,
    input logic                  swIrq_i
);

    int   assertFails = 0;
    logic rdAccept;
    logic rstWrite;

    assign rdAccept = busReq_i.req && !busReq_i.we;
    assign rstWrite = busReq_i.req && busReq_i.we && busReq_i.addr[23:0] == SB_REG_RESET;

    resetClears: assert property (@(posedge clk_i)
        rst_i |=> (led_i == '0 && !swIrq_i && busRdata_i == '0))
        else begin
            assertFails++;
            $error("outputs not cleared one cycle after reset");
        end

    outputsKnown: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown({busRdata_i, led_i, swIrq_i}))
        else begin
            assertFails++;
            $error("an output of the subsystem is unknown");
        end

    fieldsKnown: assert property (@(posedge clk_i) disable iff (rst_i)
        busReq_i.req |-> !$isunknown({busReq_i.we, busReq_i.addr, busReq_i.wdata}))
        else begin
            assertFails++;
            $error("bus request fields unknown while req is high");
        end

    // soft reset of a device clears its read data.
    rdataHolds: assert property (@(posedge clk_i) disable iff (rst_i)
        (!rdAccept && !rstWrite) |=> $stable(busRdata_i))
        else begin
            assertFails++;
            $error("bus read data changed without a read");
        end

endmodule

bind periphSubsystem periphSubsystemAssertions u_assertions (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .busReq_i   (busReq_i),
    .busRdata_i (busRdata_o),
    .led_i      (led_o),
    .swIrq_i    (swIrq_o)
);

`default_nettype wire

// File: verilog/periphSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module periphSubsystem import sysBusPkg::*; #(
    parameter int BLINK_HALF = 10_000_000
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sbReq_t                  busReq_i,
    output logic [DATA_WIDTH-1:0]   busRdata_o,
    input  logic [SWITCH_WIDTH-1:0] switches_i,
    output logic [LED_WIDTH-1:0]    led_o,
    output logic                    swIrq_o
);

    sbReq_t                ledReq;
    sbReq_t                swReq;
    logic [DATA_WIDTH-1:0] ledRdata;
    logic [DATA_WIDTH-1:0] swRdata;

    busDecoder u_decoder (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .busReq_i   (busReq_i),
        .ledReq_o   (ledReq),
        .swReq_o    (swReq),
        .ledRdata_i (ledRdata),
        .swRdata_i  (swRdata),
        .busRdata_o (busRdata_o)
    );

    ledSbCtrl #(
        .BLINK_HALF (BLINK_HALF)
    ) u_led (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (ledReq),
        .rdata_o (ledRdata),
        .led_o   (led_o)
    );

    switchSbCtrl u_switch (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (swReq),
        .switches_i (switches_i),
        .rdata_o    (swRdata),
        .irq_o      (swIrq_o)
    );

endmodule

`default_nettype wire

// File: verilog/switchSbCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module switchSbCtrl import sysBusPkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sbReq_t                  req_i,
    input  logic [SWITCH_WIDTH-1:0] switches_i,
    output logic [DATA_WIDTH-1:0]   rdata_o,
    output logic                    irq_o
);

    sbReg_e regSel;
    logic   rdAccept;
    logic   valueRd;
    logic   rstWr;
    logic   swChanged;

    logic [SWITCH_WIDTH-1:0] swMeta;
    logic [SWITCH_WIDTH-1:0] swSync;
    logic [SWITCH_WIDTH-1:0] swPrev;

    assign regSel   = sbReg_e'(req_i.addr[23:0]);
    assign rdAccept = req_i.req & ~req_i.we;
    assign valueRd  = rdAccept && regSel == SB_REG_VALUE;
    assign rstWr    = req_i.req && req_i.we && regSel == SB_REG_RESET
                      && req_i.wdata == DATA_WIDTH'(1);

    // switches are asynchronous to clk_i.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            swMeta <= '0;
            swSync <= '0;
            swPrev <= '0;
        end else begin
            swMeta <= switches_i;
            swSync <= swMeta;
            swPrev <= swSync;
        end
    end

    assign swChanged = swSync != swPrev;

    // a fresh change wins over a clearing read.
    always_ff @(posedge clk_i) begin
        if (rst_i || rstWr) begin
            irq_o <= 1'b0;
        end else if (swChanged) begin
            irq_o <= 1'b1;
        end else if (valueRd) begin
            irq_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || rstWr) begin
            rdata_o <= '0;
        end else if (rdAccept) begin
            if (valueRd) begin
                rdata_o <= DATA_WIDTH'(swSync);
            end else begin
                rdata_o <= '0;    // no other readable register.
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ledSbCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module ledSbCtrl import sysBusPkg::*; #(
    parameter int BLINK_HALF = 10_000_000
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  sbReq_t                req_i,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic [LED_WIDTH-1:0]  led_o
);

    typedef enum logic {
        MODE_STEADY = 1'b0,
        MODE_BLINK  = 1'b1
    } ledMode_e;

    // one blink period is lit half then dark half.
    localparam int               CNT_W    = $clog2(2 * BLINK_HALF);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(BLINK_HALF);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2 * BLINK_HALF - 1);

    sbReg_e   regSel;
    logic     wrAccept;
    logic     rdAccept;
    logic     valueWr;
    logic     modeWr;
    logic     rstWr;
    logic     softRst;

    logic [LED_WIDTH-1:0] ledValue;
    ledMode_e             ledMode;
    logic [CNT_W-1:0]     blinkCnt;

    assign regSel   = sbReg_e'(req_i.addr[23:0]);
    assign wrAccept = req_i.req & req_i.we;
    assign rdAccept = req_i.req & ~req_i.we;

    // upper bits must be clear, else the write is dropped.
    assign valueWr = wrAccept && regSel == SB_REG_VALUE
                     && req_i.wdata[DATA_WIDTH-1:LED_WIDTH] == '0;
    assign modeWr  = wrAccept && regSel == SB_REG_MODE
                     && req_i.wdata[DATA_WIDTH-1:1] == '0;
    assign rstWr   = wrAccept && regSel == SB_REG_RESET
                     && req_i.wdata == DATA_WIDTH'(1);
    assign softRst = rst_i | rstWr;

    always_ff @(posedge clk_i) begin
        if (softRst) begin
            ledValue <= '0;
        end else if (valueWr) begin
            ledValue <= req_i.wdata[LED_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (softRst) begin
            ledMode <= MODE_STEADY;
        end else if (modeWr) begin
            ledMode <= ledMode_e'(req_i.wdata[0]);
        end
    end

    // restarts on every mode write.
    always_ff @(posedge clk_i) begin
        if (softRst || modeWr) begin
            blinkCnt <= '0;
        end else if (ledMode == MODE_BLINK) begin
            if (blinkCnt == CNT_LAST) begin
                blinkCnt <= '0;
            end else begin
                blinkCnt <= blinkCnt + 1'b1;
            end
        end
    end

    assign led_o = (ledMode == MODE_BLINK && blinkCnt >= CNT_HALF) ? '0 : ledValue;

    always_ff @(posedge clk_i) begin
        if (softRst) begin
            rdata_o <= '0;
        end else if (rdAccept) begin
            case (regSel)
                SB_REG_VALUE: rdata_o <= DATA_WIDTH'(ledValue);
                SB_REG_MODE:  rdata_o <= DATA_WIDTH'(ledMode);
                default:      rdata_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/busDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module busDecoder import sysBusPkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  sbReq_t                busReq_i,
    output sbReq_t                ledReq_o,
    output sbReq_t                swReq_o,
    input  logic [DATA_WIDTH-1:0] ledRdata_i,
    input  logic [DATA_WIDTH-1:0] swRdata_i,
    output logic [DATA_WIDTH-1:0] busRdata_o
);

    sbDevice_e devSel;
    sbDevice_e rdDev;    // device of the last accepted read.
    logic      rdAccept;

    // forwards the request with the offset only; req only on a hit.
    function automatic sbReq_t routeReq(input sbReq_t req, input logic hit);
        sbReq_t fwd;
        fwd      = req;
        fwd.req  = req.req & hit;
        fwd.addr = {8'h00, req.addr[23:0]};
        return fwd;
    endfunction

    assign devSel   = sbDevice_e'(busReq_i.addr[31:24]);
    assign rdAccept = busReq_i.req & ~busReq_i.we;

    assign ledReq_o = routeReq(busReq_i, devSel == SB_DEV_LED);
    assign swReq_o  = routeReq(busReq_i, devSel == SB_DEV_SWITCH);

    // devices register their data on the same edge.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdDev <= sbDevice_e'(8'h00);
        end else if (rdAccept) begin
            rdDev <= devSel;
        end
    end

    always_comb begin
        case (rdDev)
            SB_DEV_LED:    busRdata_o = ledRdata_i;
            SB_DEV_SWITCH: busRdata_o = swRdata_i;
            default:       busRdata_o = '0;    // unmapped device.
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/sysBusPkg.sv
`default_nettype none

package sysBusPkg;

    localparam int DATA_WIDTH   = 32;
    localparam int LED_WIDTH    = 16;
    localparam int SWITCH_WIDTH = 16;

    // one single-word request, master to decoder and decoder to device.
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [31:0]           addr;
        logic [DATA_WIDTH-1:0] wdata;
    } sbReq_t;

    // device code in addr[31:24].
    typedef enum logic [7:0] {
        SB_DEV_SWITCH = 8'h01,
        SB_DEV_LED    = 8'h02
    } sbDevice_e;

    // register offsets inside a device.
    typedef enum logic [23:0] {
        SB_REG_VALUE = 24'h00_0000,
        SB_REG_MODE  = 24'h00_0004,
        SB_REG_RESET = 24'h00_0024
    } sbReg_e;

endpackage

`default_nettype wire
